//--- Bender.yml
package:
  name: cam_gray_scaler

sources:
  - include_dirs:
      - .
    files:
      - cam_gray_pkg.sv
      - cam_byte_packer.sv
      - nn_decimator.sv
      - rgb_to_luma.sv
      - credit_tx_fifo.sv
      - cam_gray_scaler.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cam_gray_scaler.sv

//--- cam_byte_packer.sv
// camera byte packer, rgb888 assembly with column, row and frame start tracking
`default_nettype none

`include "cam_gray_macros.svh"

module cam_byte_packer #(
    parameter int unsigned SRC_W = `CGS_SRC_W  // pixels per source line
) (
    input  wire                     i_arst_n,
    input  wire                     vtc_vs_out,
    input  wire                     i_cam_vsync,    // high during vertical blanking
    input  wire                     i_cam_href,     // high on active bytes
    input  wire [7:0]               i_cam_data,     // r, g, b byte order
    output logic                    o_pix_valid,
    output cam_gray_pkg::rgb_pix_t  o_pix_rgb,
    output cam_gray_pkg::coord_t    o_pix_col,
    output cam_gray_pkg::coord_t    o_pix_row,
    output logic                    o_frame_start   // one pulse per vsync fall
);
    import cam_gray_pkg::*;

    logic [1:0] phase_q;    // 0 red, 1 green, 2 blue
    logic [7:0] red_q;
    logic [7:0] green_q;
    logic       vsync_q;
    coord_t     col_q;      // coordinate for the pixel being gathered
    coord_t     row_q;
    logic       vs_fall;
    logic       pix_done;

    assign vs_fall  = vsync_q & ~i_cam_vsync;
    assign pix_done = i_cam_href & (phase_q == 2'd2);   // blue byte on the bus

    always_ff @(posedge vtc_vs_out or negedge i_arst_n) begin
        if (!i_arst_n) begin
            phase_q       <= 2'd0;
            vsync_q       <= 1'b0;
            col_q         <= '0;
            row_q         <= '0;
            o_pix_valid   <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            vsync_q       <= i_cam_vsync;
            o_frame_start <= vs_fall;
            o_pix_valid   <= pix_done;
            // phase restarts on every href gap
            if (!i_cam_href || pix_done) begin
                phase_q <= 2'd0;
            end else begin
                phase_q <= phase_q + 2'd1;
            end
            if (vs_fall) begin
                col_q <= '0;
                row_q <= '0;
            end else if (pix_done) begin
                if (col_q == coord_t'(SRC_W - 1)) begin   // last pixel of the line
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge vtc_vs_out) begin
        if (i_cam_href && phase_q == 2'd0) red_q <= i_cam_data;
        if (i_cam_href && phase_q == 2'd1) green_q <= i_cam_data;
        if (pix_done) begin
            o_pix_rgb <= {red_q, green_q, i_cam_data};
            o_pix_col <= col_q;
            o_pix_row <= row_q;
        end
    end

endmodule

`default_nettype wire

//--- cam_gray_macros.svh
// frame sizes, coordinate width, grey weights, credit count and output fifo depth
`ifndef CAM_GRAY_MACROS_SVH
`define CAM_GRAY_MACROS_SVH

// source frame as delivered by the camera
`define CGS_SRC_W 640
`define CGS_SRC_H 480

// frame after nearest-neighbour decimation
`define CGS_DST_W 64
`define CGS_DST_H 64

// bits per column or row index, covers 2047
`define CGS_COORD_W 11

// bt.601 style weights scaled by 256, they sum to 256
`define CGS_LUMA_R 77
`define CGS_LUMA_G 150
`define CGS_LUMA_B 29

// credits granted by the consumer after reset
`define CGS_CREDIT_INIT 4

// entries in the output fifo
`define CGS_FIFO_DEPTH 8

`endif

//--- cam_gray_pkg.sv
// package with the rgb888 pixel, grey value, coordinate and credit counter types
`default_nettype none

`include "cam_gray_macros.svh"

package cam_gray_pkg;

    // red in the top byte, blue in the bottom byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_pix_t;

    // 8-bit grey value
    typedef logic [7:0] luma_t;

    // column or row index in the source frame
    typedef logic [`CGS_COORD_W-1:0] coord_t;

    // counter width that still holds the initial grant
    localparam int unsigned CRED_W = $clog2(`CGS_CREDIT_INIT + 1);

    typedef logic [CRED_W-1:0] cred_cnt_t;

endpackage

`default_nettype wire

//--- cam_gray_scaler.f
+incdir+.
cam_gray_pkg.sv
cam_byte_packer.sv
nn_decimator.sv
rgb_to_luma.sv
credit_tx_fifo.sv
cam_gray_scaler.sv
tb_cam_gray_scaler.sv

//--- cam_gray_scaler.sv
// top level, camera bytes to decimated grey pixels under credit flow control
`default_nettype none

`include "cam_gray_macros.svh"

module cam_gray_scaler #(
    parameter int unsigned SRC_W = `CGS_SRC_W,
    parameter int unsigned SRC_H = `CGS_SRC_H,
    parameter int unsigned DST_W = `CGS_DST_W,
    parameter int unsigned DST_H = `CGS_DST_H
) (
    input  wire                     i_arst_n,
    input  wire                     vtc_vs_out,
    input  wire                     i_cam_vsync,
    input  wire                     i_cam_href,
    input  wire [7:0]               i_cam_data,
    input  wire                     i_credit,
    output logic                    o_pix_valid,
    output cam_gray_pkg::luma_t     o_pix_data,
    output logic                    o_pix_sof,
    output logic                    o_pix_eol,
    output logic                    o_overflow
);

    logic                   frame_start;    // to decimator and fifo
    logic                   pix_valid;
    cam_gray_pkg::rgb_pix_t pix_rgb;
    cam_gray_pkg::coord_t   pix_col;
    cam_gray_pkg::coord_t   pix_row;
    logic                   sel_valid;
    cam_gray_pkg::rgb_pix_t sel_rgb;
    logic                   sel_sof;
    logic                   sel_eol;
    logic                   luma_valid;
    cam_gray_pkg::luma_t    luma_data;
    logic                   luma_sof;
    logic                   luma_eol;

    cam_byte_packer #(
        .SRC_W(SRC_W)
    ) cam_byte_packer_i (
        .i_arst_n     (i_arst_n),
        .vtc_vs_out   (vtc_vs_out),
        .i_cam_vsync  (i_cam_vsync),
        .i_cam_href   (i_cam_href),
        .i_cam_data   (i_cam_data),
        .o_pix_valid  (pix_valid),
        .o_pix_rgb    (pix_rgb),
        .o_pix_col    (pix_col),
        .o_pix_row    (pix_row),
        .o_frame_start(frame_start)
    );

    nn_decimator #(
        .SRC_W(SRC_W),
        .SRC_H(SRC_H),
        .DST_W(DST_W),
        .DST_H(DST_H)
    ) nn_decimator_i (
        .i_arst_n     (i_arst_n),
        .vtc_vs_out   (vtc_vs_out),
        .i_frame_start(frame_start),
        .i_pix_valid  (pix_valid),
        .i_pix_rgb    (pix_rgb),
        .i_pix_col    (pix_col),
        .i_pix_row    (pix_row),
        .o_sel_valid  (sel_valid),
        .o_sel_rgb    (sel_rgb),
        .o_sel_sof    (sel_sof),
        .o_sel_eol    (sel_eol)
    );

    rgb_to_luma rgb_to_luma_i (
        .i_arst_n  (i_arst_n),
        .vtc_vs_out(vtc_vs_out),
        .i_valid   (sel_valid),
        .i_rgb     (sel_rgb),
        .i_sof     (sel_sof),
        .i_eol     (sel_eol),
        .o_valid   (luma_valid),
        .o_luma    (luma_data),
        .o_sof     (luma_sof),
        .o_eol     (luma_eol)
    );

    credit_tx_fifo #(
        .DEPTH      (`CGS_FIFO_DEPTH),
        .CREDIT_INIT(`CGS_CREDIT_INIT)
    ) credit_tx_fifo_i (
        .i_arst_n     (i_arst_n),
        .vtc_vs_out   (vtc_vs_out),
        .i_frame_start(frame_start),
        .i_valid      (luma_valid),
        .i_luma       (luma_data),
        .i_sof        (luma_sof),
        .i_eol        (luma_eol),
        .i_credit     (i_credit),
        .o_pix_valid  (o_pix_valid),
        .o_pix_data   (o_pix_data),
        .o_pix_sof    (o_pix_sof),
        .o_pix_eol    (o_pix_eol),
        .o_overflow   (o_overflow)
    );

endmodule

`default_nettype wire

//--- credit_tx_fifo.sv
// output fifo for grey pixels, credit based sending and sticky overflow flag
`default_nettype none

`include "cam_gray_macros.svh"

module credit_tx_fifo #(
    parameter int unsigned DEPTH       = `CGS_FIFO_DEPTH,
    parameter int unsigned CREDIT_INIT = `CGS_CREDIT_INIT
) (
    input  wire                     i_arst_n,
    input  wire                     vtc_vs_out,
    input  wire                     i_frame_start,  // clears the overflow flag
    input  wire                     i_valid,
    input  wire cam_gray_pkg::luma_t i_luma,
    input  wire                     i_sof,
    input  wire                     i_eol,
    input  wire                     i_credit,       // one credit back per pulse
    output logic                    o_pix_valid,
    output cam_gray_pkg::luma_t     o_pix_data,
    output logic                    o_pix_sof,
    output logic                    o_pix_eol,
    output logic                    o_overflow
);
    import cam_gray_pkg::*;

    localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [AW-1:0] ptr_t;

    luma_t       mem_luma [DEPTH];
    logic        mem_sof  [DEPTH];
    logic        mem_eol  [DEPTH];
    ptr_t        wr_ptr_q;
    ptr_t        rd_ptr_q;
    logic [AW:0] count_q;       // entries held
    cred_cnt_t   credit_q;      // credits left at the consumer
    logic        push;
    logic        pop;
    logic        drop;

    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = i_valid & (count_q < (AW+1)'(DEPTH));
    assign drop = i_valid & ~push;                      // camera cannot wait
    assign pop  = (count_q != '0) & (credit_q != '0);   // one send per cycle

    always_ff @(posedge vtc_vs_out or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            credit_q    <= cred_cnt_t'(CREDIT_INIT);
            o_pix_valid <= 1'b0;
            o_pix_sof   <= 1'b0;
            o_pix_eol   <= 1'b0;
            o_overflow  <= 1'b0;
        end else begin
            o_pix_valid <= pop;
            o_pix_sof   <= pop & mem_sof[rd_ptr_q];
            o_pix_eol   <= pop & mem_eol[rd_ptr_q];
            if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push && pop) begin
                count_q <= count_q - 1'b1;
            end
            // send and return in one cycle cancel out
            if (pop && !i_credit) begin
                credit_q <= credit_q - 1'b1;
            end else if (!pop && i_credit) begin
                credit_q <= credit_q + 1'b1;
            end
            if (drop) begin
                o_overflow <= 1'b1;     // sticky for the rest of the frame
            end else if (i_frame_start) begin
                o_overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge vtc_vs_out) begin
        if (push) begin
            mem_luma[wr_ptr_q] <= i_luma;
            mem_sof[wr_ptr_q]  <= i_sof;
            mem_eol[wr_ptr_q]  <= i_eol;
        end
        if (pop) o_pix_data <= mem_luma[rd_ptr_q];
    end

    // consumer never hands back more than it was granted
    a_credit_max: assert property (@(posedge vtc_vs_out) disable iff (!i_arst_n)
        credit_q <= cred_cnt_t'(CREDIT_INIT))
        else $error("credit count above the initial grant");

    // count stays within the depth and an empty fifo has matching pointers
    a_no_underflow: assert property (@(posedge vtc_vs_out) disable iff (!i_arst_n)
        (count_q <= (AW+1)'(DEPTH)) && ((count_q != '0) || (wr_ptr_q == rd_ptr_q)))
        else $error("fifo count out of range or pointers apart while empty");

endmodule

`default_nettype wire

//--- nn_decimator.sv
// nearest-neighbour decimator with modulo accumulators, marks frame start and line end
`default_nettype none

`include "cam_gray_macros.svh"

module nn_decimator #(
    parameter int unsigned SRC_W = `CGS_SRC_W,
    parameter int unsigned SRC_H = `CGS_SRC_H,
    parameter int unsigned DST_W = `CGS_DST_W,
    parameter int unsigned DST_H = `CGS_DST_H
) (
    input  wire                     i_arst_n,
    input  wire                     vtc_vs_out,
    input  wire                     i_frame_start,
    input  wire                     i_pix_valid,
    input  wire cam_gray_pkg::rgb_pix_t i_pix_rgb,
    input  wire cam_gray_pkg::coord_t   i_pix_col,
    input  wire cam_gray_pkg::coord_t   i_pix_row,
    output logic                    o_sel_valid,
    output cam_gray_pkg::rgb_pix_t  o_sel_rgb,
    output logic                    o_sel_sof,
    output logic                    o_sel_eol
);
    import cam_gray_pkg::*;

    typedef logic [`CGS_COORD_W:0] acc_t;   // spare bit for acc + dst

    coord_t col_acc_q;      // (x * DST_W) mod SRC_W of the last pixel
    coord_t row_acc_q;      // (y * DST_H) mod SRC_H of the current line
    coord_t keep_cnt_q;     // kept columns so far in this line
    logic   sof_armed_q;    // next (0,0) carries sof
    acc_t   col_sum;
    acc_t   row_sum;
    coord_t col_step;
    coord_t row_step;
    coord_t col_rem;
    coord_t row_rem;
    coord_t keep_idx;
    logic   line_first;
    logic   sof_hit;
    logic   col_keep;
    logic   row_keep;
    logic   pick;

    // one step of each accumulator, wraps at the source size
    assign col_sum  = acc_t'(col_acc_q) + acc_t'(DST_W);
    assign row_sum  = acc_t'(row_acc_q) + acc_t'(DST_H);
    assign col_step = (col_sum >= acc_t'(SRC_W)) ? coord_t'(col_sum - acc_t'(SRC_W))
                                                 : coord_t'(col_sum);
    assign row_step = (row_sum >= acc_t'(SRC_H)) ? coord_t'(row_sum - acc_t'(SRC_H))
                                                 : coord_t'(row_sum);

    assign line_first = (i_pix_col == '0);
    assign sof_hit    = line_first & (i_pix_row == '0);
    assign col_rem    = line_first ? '0 : col_step;
    assign row_rem    = !line_first ? row_acc_q :      // row remainder fixed within a line
                        (i_pix_row == '0) ? '0 : row_step;

    assign col_keep = (col_rem < coord_t'(DST_W));
    assign row_keep = (row_rem < coord_t'(DST_H));
    assign keep_idx = line_first ? '0 : keep_cnt_q;
    assign pick     = i_pix_valid & col_keep & row_keep;

    always_ff @(posedge vtc_vs_out or negedge i_arst_n) begin
        if (!i_arst_n) begin
            col_acc_q   <= '0;
            row_acc_q   <= '0;
            keep_cnt_q  <= '0;
            sof_armed_q <= 1'b1;
            o_sel_valid <= 1'b0;
            o_sel_sof   <= 1'b0;
            o_sel_eol   <= 1'b0;
        end else begin
            o_sel_valid <= pick;
            o_sel_sof   <= pick & sof_hit & sof_armed_q;
            o_sel_eol   <= pick & (keep_idx == coord_t'(DST_W - 1));   // last kept column
            if (i_frame_start) begin
                sof_armed_q <= 1'b1;
            end else if (pick && sof_hit) begin
                sof_armed_q <= 1'b0;
            end
            if (i_pix_valid) begin
                col_acc_q <= col_rem;
                row_acc_q <= row_rem;
                if (col_keep) keep_cnt_q <= keep_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge vtc_vs_out) begin
        if (pick) o_sel_rgb <= i_pix_rgb;
    end

    // decimation only, no upscaling
    a_dst_fits: assert property (@(posedge vtc_vs_out) disable iff (!i_arst_n)
        (DST_W <= SRC_W) && (DST_H <= SRC_H))
        else $error("decimated frame larger than the source frame");

endmodule

`default_nettype wire

//--- rgb_to_luma.sv
// registered rgb888 to 8-bit grey conversion by weighted sum
`default_nettype none

`include "cam_gray_macros.svh"

module rgb_to_luma (
    input  wire                     i_arst_n,
    input  wire                     vtc_vs_out,
    input  wire                     i_valid,
    input  wire cam_gray_pkg::rgb_pix_t i_rgb,
    input  wire                     i_sof,
    input  wire                     i_eol,
    output logic                    o_valid,
    output cam_gray_pkg::luma_t     o_luma,
    output logic                    o_sof,
    output logic                    o_eol
);
    import cam_gray_pkg::*;

    logic [15:0] wsum;      // max 255 * 256, fits
    luma_t       luma_d;

    assign wsum = 16'(`CGS_LUMA_R) * 16'(i_rgb.r)
                + 16'(`CGS_LUMA_G) * 16'(i_rgb.g)
                + 16'(`CGS_LUMA_B) * 16'(i_rgb.b);
    assign luma_d = wsum[15:8];     // floor of sum / 256

    always_ff @(posedge vtc_vs_out or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            o_sof   <= 1'b0;
            o_eol   <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_sof   <= i_valid & i_sof;   // markers ride with the pixel
            o_eol   <= i_valid & i_eol;
        end
    end

    always_ff @(posedge vtc_vs_out) begin
        if (i_valid) o_luma <= luma_d;
    end

endmodule

`default_nettype wire

//--- tb_cam_gray_scaler.sv
// testbench for the camera grey scaler, random frames checked against a reference model
`default_nettype none

`include "cam_gray_macros.svh"

module tb_cam_gray_scaler;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SRC_W     = 40;
    localparam int SRC_H     = 30;
    localparam int DST_W     = 8;
    localparam int DST_H     = 6;
    localparam int N_FRAMES  = 5;     // one credit hold frame then four free running frames
    localparam int FRAME_CYC = SRC_H * (SRC_W * 6 + 8) + 400;   // worst case with gaps and drain
    localparam int WD_NS     = 2 * N_FRAMES * FRAME_CYC * 40;
    localparam int SEED      = 96225;

    logic        vtc_vs_out;
    logic        i_arst_n;
    logic        i_cam_vsync;
    logic        i_cam_href;
    logic [7:0]  i_cam_data;
    logic        i_credit;
    logic        o_pix_valid;
    logic [7:0]  o_pix_data;
    logic        o_pix_sof;
    logic        o_pix_eol;
    logic        o_overflow;

    logic [9:0]  exp_q[$];      // {sof, eol, grey}
    int          err_cnt;
    int          pix_checked;
    int          frame_rx;      // pixels seen since the last frame start
    int          owed;          // credits the consumer still has to hand back
    int          credit_wait;   // cycles until the next credit pulse
    bit          credit_en;

    cam_gray_scaler #(
        .SRC_W(SRC_W),
        .SRC_H(SRC_H),
        .DST_W(DST_W),
        .DST_H(DST_H)
    ) cam_gray_scaler_i (
        .i_arst_n   (i_arst_n),
        .vtc_vs_out (vtc_vs_out),
        .i_cam_vsync(i_cam_vsync),
        .i_cam_href (i_cam_href),
        .i_cam_data (i_cam_data),
        .i_credit   (i_credit),
        .o_pix_valid(o_pix_valid),
        .o_pix_data (o_pix_data),
        .o_pix_sof  (o_pix_sof),
        .o_pix_eol  (o_pix_eol),
        .o_overflow (o_overflow)
    );

    always #20 vtc_vs_out = ~vtc_vs_out;    // 40 ns period

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // n rising edges then the drive delay
    task automatic tick(input int n);
        repeat (n) @(posedge vtc_vs_out);
        #2;
    endtask

    // floor of the weighted sum over 256
    function automatic logic [7:0] grey_of(input logic [7:0] r, input logic [7:0] g,
                                           input logic [7:0] b);
        int sum;
        sum = `CGS_LUMA_R * r + `CGS_LUMA_G * g + `CGS_LUMA_B * b;
        return sum / 256;
    endfunction

    // nearest-neighbour selection of one index
    function automatic bit kept(input int idx, input int dst, input int src);
        return ((idx * dst) % src) < dst;
    endfunction

    task automatic send_pixel(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
        i_cam_href = 1'b1;
        i_cam_data = r;
        tick(1);
        i_cam_data = g;
        tick(1);
        i_cam_data = b;
        tick(1);
    endtask

    // bounded wait for the expected queue to empty
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 300) begin
            tick(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected pixels never arrived at the output", exp_q.size());
            exp_q.delete();
        end
        tick(4);    // room for stray extra pixels
    endtask

    task automatic run_frame(input bit hold, input bit gaps);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [9:0] ent;
        int         kept_cnt;
        int         line_kept;
        credit_en   = !hold;
        i_cam_vsync = 1'b1;
        tick(20 + $urandom % 20);   // vertical blanking
        i_cam_vsync = 1'b0;
        tick(4);
        frame_rx = 0;
        compare("ovf_clear", 0, o_overflow);    // cleared by the frame start
        kept_cnt = 0;
        for (int y = 0; y < SRC_H; y++) begin
            line_kept = 0;
            for (int x = 0; x < SRC_W; x++) begin
                r = $urandom;
                g = $urandom;
                b = $urandom;
                if (kept(x, DST_W, SRC_W) && kept(y, DST_H, SRC_H)) begin
                    line_kept++;
                    ent = {(x == 0 && y == 0), (line_kept == DST_W), grey_of(r, g, b)};
                    // held frame keeps only what fits in flight plus fifo
                    if (!hold || kept_cnt < `CGS_CREDIT_INIT + `CGS_FIFO_DEPTH) begin
                        exp_q.push_back(ent);
                    end
                    kept_cnt++;
                end
                send_pixel(r, g, b);
                if (gaps && x != SRC_W - 1 && $urandom % 4 == 0) begin
                    i_cam_href = 1'b0;      // short gap between two pixels
                    tick(1 + $urandom % 3);
                end
            end
            i_cam_href = 1'b0;
            tick(2 + $urandom % 5);     // line blanking
        end
        i_cam_vsync = 1'b1;
        tick(8);    // pipeline flush
        if (hold) begin
            compare("hold_sent", `CGS_CREDIT_INIT, frame_rx);
            compare("hold_ovf", 1, o_overflow);
            credit_en = 1'b1;   // consumer catches up in blanking
            wait_drain();
            compare("hold_total", `CGS_CREDIT_INIT + `CGS_FIFO_DEPTH, frame_rx);
        end else begin
            wait_drain();
            compare("frame_pixels", DST_W * DST_H, frame_rx);
            compare("ovf_low", 0, o_overflow);
        end
    endtask

    // output monitor sampled mid cycle
    always @(negedge vtc_vs_out) begin : monitor
        logic [9:0] ent;
        if (i_arst_n && o_pix_valid) begin
            frame_rx++;
            owed++;
            pix_checked++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("output pixel %0d arrived while none was expected", o_pix_data);
            end else begin
                ent = exp_q.pop_front();
                compare("grey", ent[7:0], o_pix_data);
                compare("sof", ent[9], o_pix_sof);
                compare("eol", ent[8], o_pix_eol);
            end
        end
    end

    // consumer returns one credit per pulse after 1 to 4 cycles
    always @(posedge vtc_vs_out) begin
        #2;
        i_credit = 1'b0;
        if (credit_wait > 0) begin
            credit_wait--;
            if (credit_wait == 0) begin
                i_credit = 1'b1;
                owed--;
            end
        end else if (credit_en && owed > 0) begin
            credit_wait = 1 + $urandom % 4;
        end
    end

    initial begin
        void'($urandom(SEED));
        vtc_vs_out  = 1'b0;
        i_arst_n    = 1'b0;
        i_cam_vsync = 1'b1;     // start in blanking
        i_cam_href  = 1'b0;
        i_cam_data  = 8'h00;
        i_credit    = 1'b0;
        err_cnt     = 0;
        pix_checked = 0;
        frame_rx    = 0;
        owed        = 0;
        credit_wait = 0;
        credit_en   = 1'b0;
        tick(10);
        i_arst_n = 1'b1;
        tick(1);
        compare("reset_valid", 0, o_pix_valid);
        compare("reset_ovf", 0, o_overflow);
        run_frame(1'b1, 1'b0);      // no credits back for the whole first frame
        for (int f = 1; f < N_FRAMES; f++) begin
            run_frame(1'b0, f >= 3);    // href gaps in the last two
        end
        tick(10);
        $display("closing: %0d pixels checked, %0d errors", pix_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WD_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
